//--- logic/tcdm_dma_pkg.sv
package tcdm_dma_pkg;

   localparam int NUM_CHANNELS = 4;
   localparam int CH_W         = 2;   // channel index bits
   localparam int ADDR_W       = 20;
   localparam int DATA_W       = 32;
   localparam int BE_W         = 4;
   localparam int LEN_W        = 8;
   localparam int BUF_DEPTH    = 64;
   localparam int BUF_AW       = 6;
   localparam int PAGE_LSB     = 12;  // address bits above this pick the region

   // register map, page 0
   localparam logic [ADDR_W-1:0] REG_CFG_BASE    = 20'h000;
   localparam logic [ADDR_W-1:0] REG_LEN_BASE    = 20'h010;
   localparam logic [ADDR_W-1:0] REG_DATA_BASE   = 20'h080;
   localparam logic [ADDR_W-1:0] REG_STATUS      = 20'h0A0;
   localparam logic [ADDR_W-1:0] REG_LAUNCH_BASE = 20'h200;
   localparam logic [ADDR_W-1:0] REG_ID          = 20'h800;

   localparam logic [ADDR_W-PAGE_LSB-1:0] BUF_REGION_BASE = 8'h01;  // buffer c at base + c
   localparam logic [DATA_W-1:0]          ID_VALUE        = 32'hCA11_EF3A;

   typedef struct packed {
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [BE_W-1:0]   be;
   } bus_req_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [BE_W-1:0]   be;
      logic              dir;   // 1 reads TCDM into the buffer
      logic [LEN_W-1:0]  len;
   } chan_cfg_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              we;
      logic [BE_W-1:0]   be;
      logic [DATA_W-1:0] wdata;
   } tcdm_req_t;

endpackage

//--- logic/chan_buffer.sv
`timescale 1ns/100ps
module chan_buffer (
   input  logic                            CLK,
   input  logic                            a_en,
   input  logic                            a_we,
   input  logic [tcdm_dma_pkg::BUF_AW-1:0] a_addr,
   input  logic [tcdm_dma_pkg::DATA_W-1:0] a_wdata,
   output logic [tcdm_dma_pkg::DATA_W-1:0] a_rdata,
   input  logic                            b_we,
   input  logic [tcdm_dma_pkg::BUF_AW-1:0] b_addr,
   input  logic [tcdm_dma_pkg::DATA_W-1:0] b_wdata,
   output logic [tcdm_dma_pkg::DATA_W-1:0] b_rdata
);

   logic [tcdm_dma_pkg::DATA_W-1:0] mem [tcdm_dma_pkg::BUF_DEPTH];
   logic                            a_write;

   // port B owns a word both ports write in the same cycle
   assign a_write = a_en && a_we && !(b_we && b_addr == a_addr);

   always_ff @(posedge CLK) begin
      if (a_write)
         mem[a_addr] <= a_wdata;
      if (b_we)
         mem[b_addr] <= b_wdata;
   end

   always_ff @(posedge CLK) begin
      if (a_en)
         a_rdata <= mem[a_addr];   // held until the next access
      b_rdata <= mem[b_addr];
   end

endmodule

//--- logic/tcdm_channel.sv
`timescale 1ns/100ps
module tcdm_channel (
   input  logic                            CLK,
   input  logic                            reset,
   input  tcdm_dma_pkg::chan_cfg_t         cfg,
   input  logic                            start_single,
   input  logic                            start_burst,
   input  logic [tcdm_dma_pkg::DATA_W-1:0] single_wdata,
   output logic                            busy,
   output logic [tcdm_dma_pkg::DATA_W-1:0] result,
   output logic                            tcdm_req,
   output tcdm_dma_pkg::tcdm_req_t         tcdm_req_p,
   input  logic                            tcdm_gnt,
   input  logic                            tcdm_valid,
   input  logic [tcdm_dma_pkg::DATA_W-1:0] tcdm_rdata,
   output logic                            buf_we,
   output logic [tcdm_dma_pkg::BUF_AW-1:0] buf_addr,
   output logic [tcdm_dma_pkg::DATA_W-1:0] buf_wdata,
   input  logic [tcdm_dma_pkg::DATA_W-1:0] buf_rdata
);

   typedef enum logic [2:0] {S_IDLE, S_FETCH, S_REQ, S_WAIT, S_DONE} chan_state_e;

   chan_state_e                     state;
   logic [tcdm_dma_pkg::ADDR_W-1:0] addr_q;
   logic [tcdm_dma_pkg::BE_W-1:0]   be_q;
   logic                            dir_q;
   logic                            burst_q;
   logic [tcdm_dma_pkg::LEN_W-1:0]  len_q;
   logic [tcdm_dma_pkg::LEN_W-1:0]  cnt;     // words completed
   logic [tcdm_dma_pkg::DATA_W-1:0] wdata_q;
   logic                            last_word;

   assign busy      = state != S_IDLE;
   assign tcdm_req  = state == S_REQ;
   assign last_word = (cnt + 1'b1) == len_q;

   assign tcdm_req_p.addr  = addr_q;
   assign tcdm_req_p.we    = ~dir_q;
   assign tcdm_req_p.be    = be_q;
   assign tcdm_req_p.wdata = burst_q ? buf_rdata : wdata_q;  // buffer word holds while cnt holds

   assign buf_addr  = cnt[tcdm_dma_pkg::BUF_AW-1:0];
   assign buf_we    = state == S_WAIT && tcdm_valid && burst_q && dir_q;
   assign buf_wdata = tcdm_rdata;

   always_ff @(posedge CLK) begin
      if (reset) begin
         state   <= S_IDLE;
         addr_q  <= '0;
         be_q    <= '0;
         dir_q   <= 1'b0;
         burst_q <= 1'b0;
         len_q   <= '0;
         cnt     <= '0;
         wdata_q <= '0;
         result  <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               cnt <= '0;
               if (start_single || start_burst) begin
                  addr_q  <= cfg.addr;
                  be_q    <= cfg.be;
                  dir_q   <= cfg.dir;
                  len_q   <= cfg.len;
                  burst_q <= start_burst;
                  wdata_q <= single_wdata;
               end
               if (start_single)
                  state <= S_REQ;
               else if (start_burst) begin
                  if (cfg.len == '0)
                     state <= S_DONE;
                  else if (cfg.dir)
                     state <= S_REQ;
                  else
                     state <= S_FETCH;
               end
            end
            S_FETCH: state <= S_REQ;   // buffer read in flight
            S_REQ: begin
               if (tcdm_gnt)
                  state <= S_WAIT;
            end
            S_WAIT: begin
               if (tcdm_valid) begin
                  result <= dir_q ? tcdm_rdata : tcdm_req_p.wdata;
                  cnt    <= cnt + 1'b1;
                  addr_q <= addr_q + {{(tcdm_dma_pkg::ADDR_W-3){1'b0}}, 3'd4};
                  if (!burst_q || last_word)
                     state <= S_IDLE;
                  else if (dir_q)
                     state <= S_REQ;
                  else
                     state <= S_FETCH;
               end
            end
            S_DONE:  state <= S_IDLE;  // zero-length burst
            default: state <= S_IDLE;
         endcase
      end
   end

   a_req_stable: assert property (@(posedge CLK) disable iff (reset)
      tcdm_req && !tcdm_gnt |=> tcdm_req && $stable(tcdm_req_p))
      else $error("TCDM request dropped or changed before gnt");

   a_valid_outstanding: assert property (@(posedge CLK) disable iff (reset)
      tcdm_valid |-> state == S_WAIT)
      else $error("tcdm_valid with no transfer outstanding");

endmodule

//--- logic/tcdm_regs.sv
`timescale 1ns/100ps
module tcdm_regs (
   input  logic                                      CLK,
   input  logic                                      reset,
   input  logic                                      bus_req,
   input  tcdm_dma_pkg::bus_req_t                    bus_req_p,
   output logic                                      bus_gnt,
   output logic                                      bus_valid,
   output logic [tcdm_dma_pkg::DATA_W-1:0]           bus_rdata,
   output tcdm_dma_pkg::chan_cfg_t                   cfg [tcdm_dma_pkg::NUM_CHANNELS],
   output logic [tcdm_dma_pkg::NUM_CHANNELS-1:0]     start_single,
   output logic [tcdm_dma_pkg::NUM_CHANNELS-1:0]     start_burst,
   output logic [tcdm_dma_pkg::DATA_W-1:0]           single_wdata [tcdm_dma_pkg::NUM_CHANNELS],
   input  logic [tcdm_dma_pkg::NUM_CHANNELS-1:0]     busy,
   input  logic [tcdm_dma_pkg::DATA_W-1:0]           result [tcdm_dma_pkg::NUM_CHANNELS],
   output logic [tcdm_dma_pkg::NUM_CHANNELS-1:0]     buf_en,
   output logic                                      buf_we,
   output logic [tcdm_dma_pkg::BUF_AW-1:0]           buf_addr,
   output logic [tcdm_dma_pkg::DATA_W-1:0]           buf_wdata,
   input  logic [tcdm_dma_pkg::DATA_W-1:0]           buf_rdata [tcdm_dma_pkg::NUM_CHANNELS]
);

   typedef enum logic [2:0] {S_IDLE, S_DECODE, S_ACCESS, S_GRANT, S_RESP} bus_state_e;

   bus_state_e                                      state;
   logic [tcdm_dma_pkg::DATA_W-1:0]                 cfg_reg [tcdm_dma_pkg::NUM_CHANNELS];
   logic [tcdm_dma_pkg::DATA_W-1:0]                 len_reg [tcdm_dma_pkg::NUM_CHANNELS];
   logic [tcdm_dma_pkg::ADDR_W-1:0]                 reg_base;
   logic [tcdm_dma_pkg::CH_W-1:0]                   ch;
   logic [tcdm_dma_pkg::ADDR_W-tcdm_dma_pkg::PAGE_LSB-1:0] buf_idx;
   logic [tcdm_dma_pkg::NUM_CHANNELS-1:0]           ch_onehot;
   logic [tcdm_dma_pkg::NUM_CHANNELS-1:0]           buf_hit;
   logic                                            cfg_sel;
   logic                                            len_sel;
   logic                                            data_sel;
   logic                                            launch_sel;
   logic                                            status_hit;
   logic                                            id_hit;
   logic [tcdm_dma_pkg::DATA_W-1:0]                 rd_word;

   function automatic logic [tcdm_dma_pkg::DATA_W-1:0] apply_be(
      input logic [tcdm_dma_pkg::DATA_W-1:0] old,
      input tcdm_dma_pkg::bus_req_t          req);
      logic [tcdm_dma_pkg::DATA_W-1:0] v;
      v = old;
      for (int b = 0; b < tcdm_dma_pkg::BE_W; b++) begin
         if (req.be[b])
            v[8*b +: 8] = req.wdata[8*b +: 8];
      end
      return v;
   endfunction

   // channel registers repeat every word from their base
   assign reg_base   = {bus_req_p.addr[tcdm_dma_pkg::ADDR_W-1:tcdm_dma_pkg::CH_W+2],
                        {(tcdm_dma_pkg::CH_W+2){1'b0}}};
   assign ch         = bus_req_p.addr[tcdm_dma_pkg::CH_W+1:2];
   assign ch_onehot  = {{(tcdm_dma_pkg::NUM_CHANNELS-1){1'b0}}, 1'b1} << ch;
   assign cfg_sel    = reg_base == tcdm_dma_pkg::REG_CFG_BASE;
   assign len_sel    = reg_base == tcdm_dma_pkg::REG_LEN_BASE;
   assign data_sel   = reg_base == tcdm_dma_pkg::REG_DATA_BASE;
   assign launch_sel = reg_base == tcdm_dma_pkg::REG_LAUNCH_BASE;
   assign status_hit = {bus_req_p.addr[tcdm_dma_pkg::ADDR_W-1:2], 2'b00} == tcdm_dma_pkg::REG_STATUS;
   assign id_hit     = {bus_req_p.addr[tcdm_dma_pkg::ADDR_W-1:2], 2'b00} == tcdm_dma_pkg::REG_ID;

   assign buf_idx = bus_req_p.addr[tcdm_dma_pkg::ADDR_W-1:tcdm_dma_pkg::PAGE_LSB]
                    - tcdm_dma_pkg::BUF_REGION_BASE;
   assign buf_hit = (buf_idx < tcdm_dma_pkg::NUM_CHANNELS) ?
                    {{(tcdm_dma_pkg::NUM_CHANNELS-1){1'b0}}, 1'b1}
                       << buf_idx[tcdm_dma_pkg::CH_W-1:0] : '0;

   // reads fetch as soon as the request shows, writes land with gnt
   assign buf_en    = buf_hit & {tcdm_dma_pkg::NUM_CHANNELS{bus_req &
                      ((state == S_IDLE && !bus_req_p.we) || (state == S_GRANT && bus_req_p.we))}};
   assign buf_we    = bus_req_p.we;
   assign buf_addr  = bus_req_p.addr[tcdm_dma_pkg::BUF_AW+1:2];
   assign buf_wdata = bus_req_p.wdata;

   assign bus_gnt   = state == S_GRANT;
   assign bus_valid = state == S_RESP;

   for (genvar c = 0; c < tcdm_dma_pkg::NUM_CHANNELS; c++) begin : g_cfg
      assign cfg[c].addr = cfg_reg[c][tcdm_dma_pkg::ADDR_W-1:0];
      assign cfg[c].be   = ~cfg_reg[c][tcdm_dma_pkg::ADDR_W +: tcdm_dma_pkg::BE_W];  // stored inverted
      assign cfg[c].dir  = cfg_reg[c][tcdm_dma_pkg::DATA_W-1];
      assign cfg[c].len  = len_reg[c][tcdm_dma_pkg::LEN_W-1:0];
   end

   always_comb begin
      rd_word = '0;
      if (cfg_sel)
         rd_word = cfg_reg[ch];
      else if (len_sel)
         rd_word = len_reg[ch];
      else if (data_sel)
         rd_word = result[ch];
      else if (status_hit)
         rd_word = {{(tcdm_dma_pkg::DATA_W-tcdm_dma_pkg::NUM_CHANNELS){1'b0}}, busy};
      else if (id_hit)
         rd_word = tcdm_dma_pkg::ID_VALUE;
      else if (|buf_hit)
         rd_word = buf_rdata[buf_idx[tcdm_dma_pkg::CH_W-1:0]];
   end

   always_ff @(posedge CLK) begin
      if (reset) begin
         state        <= S_IDLE;
         bus_rdata    <= '0;
         start_single <= '0;
         start_burst  <= '0;
         for (int c = 0; c < tcdm_dma_pkg::NUM_CHANNELS; c++) begin
            cfg_reg[c]      <= '0;
            len_reg[c]      <= '0;
            single_wdata[c] <= '0;
         end
      end else begin
         start_single <= '0;
         start_burst  <= '0;
         case (state)
            S_IDLE:   if (bus_req) state <= S_DECODE;
            S_DECODE: state <= S_ACCESS;
            S_ACCESS: state <= S_GRANT;
            S_GRANT: begin
               state     <= S_RESP;
               bus_rdata <= rd_word;
               if (bus_req_p.we) begin
                  for (int c = 0; c < tcdm_dma_pkg::NUM_CHANNELS; c++) begin
                     if (cfg_sel && ch_onehot[c])
                        cfg_reg[c] <= apply_be(cfg_reg[c], bus_req_p);
                     if (len_sel && ch_onehot[c])
                        len_reg[c] <= apply_be(len_reg[c], bus_req_p);
                     if (data_sel && ch_onehot[c] && !busy[c])
                        single_wdata[c] <= bus_req_p.wdata;
                  end
                  start_single <= ch_onehot & ~busy & {tcdm_dma_pkg::NUM_CHANNELS{data_sel}};
                  start_burst  <= ch_onehot & ~busy & {tcdm_dma_pkg::NUM_CHANNELS{launch_sel}};
               end
            end
            S_RESP:   state <= S_IDLE;
            default:  state <= S_IDLE;
         endcase
      end
   end

   a_valid_after_gnt: assert property (@(posedge CLK) disable iff (reset)
      $rose(bus_valid) |-> $past(bus_gnt))
      else $error("bus_valid rose without bus_gnt");

endmodule

//--- logic/tcdm_dma_top.sv
`timescale 1ns/100ps
module tcdm_dma_top (
   input  logic                                  CLK,
   input  logic                                  reset,
   input  logic                                  bus_req,
   input  tcdm_dma_pkg::bus_req_t                bus_req_p,
   output logic                                  bus_gnt,
   output logic                                  bus_valid,
   output logic [tcdm_dma_pkg::DATA_W-1:0]       bus_rdata,
   output logic [tcdm_dma_pkg::NUM_CHANNELS-1:0] tcdm_req,
   output tcdm_dma_pkg::tcdm_req_t               tcdm_req_p [tcdm_dma_pkg::NUM_CHANNELS],
   input  logic [tcdm_dma_pkg::NUM_CHANNELS-1:0] tcdm_gnt,
   input  logic [tcdm_dma_pkg::NUM_CHANNELS-1:0] tcdm_valid,
   input  logic [tcdm_dma_pkg::DATA_W-1:0]       tcdm_rdata [tcdm_dma_pkg::NUM_CHANNELS]
);

   tcdm_dma_pkg::chan_cfg_t               cfg          [tcdm_dma_pkg::NUM_CHANNELS];
   logic [tcdm_dma_pkg::NUM_CHANNELS-1:0] start_single;
   logic [tcdm_dma_pkg::NUM_CHANNELS-1:0] start_burst;
   logic [tcdm_dma_pkg::DATA_W-1:0]       single_wdata [tcdm_dma_pkg::NUM_CHANNELS];
   logic [tcdm_dma_pkg::NUM_CHANNELS-1:0] busy;
   logic [tcdm_dma_pkg::DATA_W-1:0]       result       [tcdm_dma_pkg::NUM_CHANNELS];
   logic [tcdm_dma_pkg::NUM_CHANNELS-1:0] buf_en;
   logic                                  buf_we;
   logic [tcdm_dma_pkg::BUF_AW-1:0]       buf_addr;
   logic [tcdm_dma_pkg::DATA_W-1:0]       buf_wdata;
   logic [tcdm_dma_pkg::DATA_W-1:0]       buf_rdata    [tcdm_dma_pkg::NUM_CHANNELS];
   logic [tcdm_dma_pkg::NUM_CHANNELS-1:0] ch_buf_we;
   logic [tcdm_dma_pkg::BUF_AW-1:0]       ch_buf_addr  [tcdm_dma_pkg::NUM_CHANNELS];
   logic [tcdm_dma_pkg::DATA_W-1:0]       ch_buf_wdata [tcdm_dma_pkg::NUM_CHANNELS];
   logic [tcdm_dma_pkg::DATA_W-1:0]       ch_buf_rdata [tcdm_dma_pkg::NUM_CHANNELS];

   tcdm_regs tcdm_regs_i (
      .CLK          (CLK),
      .reset        (reset),
      .bus_req      (bus_req),
      .bus_req_p    (bus_req_p),
      .bus_gnt      (bus_gnt),
      .bus_valid    (bus_valid),
      .bus_rdata    (bus_rdata),
      .cfg          (cfg),
      .start_single (start_single),
      .start_burst  (start_burst),
      .single_wdata (single_wdata),
      .busy         (busy),
      .result       (result),
      .buf_en       (buf_en),
      .buf_we       (buf_we),
      .buf_addr     (buf_addr),
      .buf_wdata    (buf_wdata),
      .buf_rdata    (buf_rdata)
   );

   for (genvar c = 0; c < tcdm_dma_pkg::NUM_CHANNELS; c++) begin : g_chan
      tcdm_channel tcdm_channel_i (
         .CLK          (CLK),
         .reset        (reset),
         .cfg          (cfg[c]),
         .start_single (start_single[c]),
         .start_burst  (start_burst[c]),
         .single_wdata (single_wdata[c]),
         .busy         (busy[c]),
         .result       (result[c]),
         .tcdm_req     (tcdm_req[c]),
         .tcdm_req_p   (tcdm_req_p[c]),
         .tcdm_gnt     (tcdm_gnt[c]),
         .tcdm_valid   (tcdm_valid[c]),
         .tcdm_rdata   (tcdm_rdata[c]),
         .buf_we       (ch_buf_we[c]),
         .buf_addr     (ch_buf_addr[c]),
         .buf_wdata    (ch_buf_wdata[c]),
         .buf_rdata    (ch_buf_rdata[c])
      );

      chan_buffer chan_buffer_i (   // port A bus, port B channel
         .CLK     (CLK),
         .a_en    (buf_en[c]),
         .a_we    (buf_we),
         .a_addr  (buf_addr),
         .a_wdata (buf_wdata),
         .a_rdata (buf_rdata[c]),
         .b_we    (ch_buf_we[c]),
         .b_addr  (ch_buf_addr[c]),
         .b_wdata (ch_buf_wdata[c]),
         .b_rdata (ch_buf_rdata[c])
      );
   end

endmodule

//--- verif/tcdm_mem_model.sv
`timescale 1ns/100ps
module tcdm_mem_model #(
   parameter int PORT = 0
) (
   input  logic                            CLK,
   input  logic                            reset,
   input  logic                            req,
   input  tcdm_dma_pkg::tcdm_req_t         req_p,
   output logic                            gnt,
   output logic                            valid,
   output logic [tcdm_dma_pkg::DATA_W-1:0] rdata
);

   logic [tcdm_dma_pkg::DATA_W-1:0] mem [256];
   logic [31:0]                     rng;
   logic [1:0]                      gnt_wait;  // cycles left before the next grant
   logic                            pend;      // granted, valid comes next cycle
   logic [7:0]                      idx;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   assign idx = req_p.addr[9:2];
   assign gnt = req && !pend && !valid && gnt_wait == 2'd0;

   always @(posedge CLK) begin
      if (reset) begin
         rng = 32'h37e8_4ed8;
         repeat (PORT) rng = lcg_next(rng);   // each port runs its own offset
         for (int i = 0; i < 256; i++)
            mem[i] = {4'hD, 4'(PORT), 8'(i), 8'(i) ^ 8'hA5, ~8'(i)};
         gnt_wait <= 2'd0;
         pend     <= 1'b0;
         valid    <= 1'b0;
         rdata    <= '0;
      end else begin
         valid <= 1'b0;
         if (gnt) begin
            rng = lcg_next(rng);
            gnt_wait <= rng[17:16];            // 0 to 3 for the next request
            if (rng[20])
               pend <= 1'b1;                   // valid two cycles after gnt
            else
               valid <= 1'b1;
            if (req_p.we) begin
               for (int b = 0; b < 4; b++)
                  if (req_p.be[b])
                     mem[idx][8*b +: 8] = req_p.wdata[8*b +: 8];
            end else
               rdata <= mem[idx];
         end else begin
            if (req && gnt_wait != 2'd0)
               gnt_wait <= gnt_wait - 2'd1;
            if (pend) begin
               pend  <= 1'b0;
               valid <= 1'b1;
            end
         end
      end
   end

endmodule

//--- verif/tb_tcdm_dma.sv
`timescale 1ns/100ps
module tb_tcdm_dma;

   typedef enum logic [1:0] {OP_WR, OP_RD, OP_POLL, OP_PEEK} op_e;

   typedef struct packed {
      op_e         op;
      logic [1:0]  port;   // model port for peeks
      logic [19:0] addr;
      logic [31:0] data;   // write data or status mask to poll
      logic [3:0]  be;
      logic [31:0] exp;
   } step_t;

   logic                                  CLK = 1'b0;
   logic                                  reset;
   logic                                  bus_req;
   tcdm_dma_pkg::bus_req_t                bus_req_p;
   logic                                  bus_gnt;
   logic                                  bus_valid;
   logic [tcdm_dma_pkg::DATA_W-1:0]       bus_rdata;
   logic [tcdm_dma_pkg::NUM_CHANNELS-1:0] tcdm_req;
   tcdm_dma_pkg::tcdm_req_t               tcdm_req_p [tcdm_dma_pkg::NUM_CHANNELS];
   logic [tcdm_dma_pkg::NUM_CHANNELS-1:0] tcdm_gnt;
   logic [tcdm_dma_pkg::NUM_CHANNELS-1:0] tcdm_valid;
   logic [tcdm_dma_pkg::DATA_W-1:0]       tcdm_rdata [tcdm_dma_pkg::NUM_CHANNELS];

   step_t steps[$];
   int    errors = 0;
   int    checks = 0;
   int    cycles = 0;
   int    limit  = 0;

   always #4 CLK = ~CLK;

   tcdm_dma_top tcdm_dma_top_i (
      .CLK        (CLK),
      .reset      (reset),
      .bus_req    (bus_req),
      .bus_req_p  (bus_req_p),
      .bus_gnt    (bus_gnt),
      .bus_valid  (bus_valid),
      .bus_rdata  (bus_rdata),
      .tcdm_req   (tcdm_req),
      .tcdm_req_p (tcdm_req_p),
      .tcdm_gnt   (tcdm_gnt),
      .tcdm_valid (tcdm_valid),
      .tcdm_rdata (tcdm_rdata)
   );

   for (genvar c = 0; c < tcdm_dma_pkg::NUM_CHANNELS; c++) begin : g_mem
      tcdm_mem_model #(.PORT(c)) tcdm_mem_model_i (
         .CLK   (CLK),
         .reset (reset),
         .req   (tcdm_req[c]),
         .req_p (tcdm_req_p[c]),
         .gnt   (tcdm_gnt[c]),
         .valid (tcdm_valid[c]),
         .rdata (tcdm_rdata[c])
      );
   end

   always @(posedge CLK) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout: the run did not finish within %0d cycles", limit);
         $display("Simulation FAILED");
         $finish;
      end
   end

   function automatic logic [19:0] chan_reg(input logic [19:0] base, input int c);
      return base + 20'(4 * c);
   endfunction

   function automatic logic [19:0] buf_word(input int c, input int w);
      return {8'(tcdm_dma_pkg::BUF_REGION_BASE + 8'(c)), 12'(4 * w)};
   endfunction

   // byte enables sit inverted in bits 23:20
   function automatic logic [31:0] cfg_word(input logic dir, input logic [3:0] be,
                                            input logic [19:0] a);
      return {dir, 7'b0, ~be, a};
   endfunction

   function automatic logic [31:0] fill_word(input int port, input logic [7:0] idx);
      return {4'hD, 4'(port), idx, idx ^ 8'hA5, ~idx};
   endfunction

   function automatic logic [31:0] peek_mem(input logic [1:0] port, input logic [19:0] a);
      logic [7:0] idx;
      idx = a[9:2];
      case (port)
         2'd0:    return g_mem[0].tcdm_mem_model_i.mem[idx];
         2'd1:    return g_mem[1].tcdm_mem_model_i.mem[idx];
         2'd2:    return g_mem[2].tcdm_mem_model_i.mem[idx];
         default: return g_mem[3].tcdm_mem_model_i.mem[idx];
      endcase
   endfunction

   task automatic append_step(input op_e op, input logic [1:0] port, input logic [19:0] a,
                              input logic [31:0] d, input logic [3:0] be, input logic [31:0] e);
      steps.push_back('{op, port, a, d, be, e});
   endtask

   task automatic push_write(input logic [19:0] a, input logic [31:0] d, input logic [3:0] be);
      append_step(OP_WR, 2'd0, a, d, be, 32'h0);
   endtask

   task automatic expect_read(input logic [19:0] a, input logic [31:0] e);
      append_step(OP_RD, 2'd0, a, 32'h0, 4'hF, e);
   endtask

   task automatic wait_idle(input logic [3:0] mask);
      append_step(OP_POLL, 2'd0, tcdm_dma_pkg::REG_STATUS, {28'h0, mask}, 4'hF, 32'h0);
   endtask

   task automatic expect_mem(input int port, input logic [19:0] a, input logic [31:0] e);
      append_step(OP_PEEK, 2'(port), a, 32'h0, 4'hF, e);
   endtask

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic bus_access(input logic wr, input logic [19:0] a, input logic [31:0] wd,
                             input logic [3:0] be, output logic [31:0] rd);
      tcdm_dma_pkg::bus_req_t p;
      int                     waited;
      p.we    = wr;
      p.addr  = a;
      p.wdata = wd;
      p.be    = be;
      @(posedge CLK);
      bus_req   <= 1'b1;
      bus_req_p <= p;
      @(negedge CLK);
      waited = 0;
      while (!bus_gnt) begin
         waited++;
         @(negedge CLK);
      end
      compare("bus_gnt delay", 32'(waited), 32'd3);   // one edge to sample, two to gnt
      @(posedge CLK);
      bus_req <= 1'b0;
      @(negedge CLK);
      if (!bus_valid) begin
         errors++;
         $display("no bus_valid in the cycle after bus_gnt, address %h", a);
      end
      rd = bus_rdata;
   endtask

   task automatic build_table();
      logic [19:0] base;
      logic [31:0] w;
      int          len;
      expect_read(tcdm_dma_pkg::REG_ID, tcdm_dma_pkg::ID_VALUE);
      expect_read(chan_reg(tcdm_dma_pkg::REG_CFG_BASE, 0), 32'h0);
      expect_read(chan_reg(tcdm_dma_pkg::REG_CFG_BASE, 3), 32'h0);
      expect_read(chan_reg(tcdm_dma_pkg::REG_LEN_BASE, 0), 32'h0);
      expect_read(chan_reg(tcdm_dma_pkg::REG_LEN_BASE, 2), 32'h0);
      expect_read(tcdm_dma_pkg::REG_STATUS, 32'h0);
      push_write(chan_reg(tcdm_dma_pkg::REG_CFG_BASE, 1), 32'h1234_5678, 4'hF);
      push_write(chan_reg(tcdm_dma_pkg::REG_CFG_BASE, 1), 32'hAABB_CCDD, 4'b0101);
      expect_read(chan_reg(tcdm_dma_pkg::REG_CFG_BASE, 1), 32'h12BB_56DD);
      push_write(chan_reg(tcdm_dma_pkg::REG_LEN_BASE, 2), 32'hFFFF_FFFF, 4'b0010);
      expect_read(chan_reg(tcdm_dma_pkg::REG_LEN_BASE, 2), 32'h0000_FF00);
      push_write(buf_word(0, 5), 32'hCAFE_0005, 4'hF);
      push_write(buf_word(3, 63), 32'h5EED_003F, 4'hF);
      expect_read(buf_word(0, 5), 32'hCAFE_0005);
      expect_read(buf_word(3, 63), 32'h5EED_003F);
      // single write, single read, then a write with two lanes off
      push_write(chan_reg(tcdm_dma_pkg::REG_CFG_BASE, 0), cfg_word(1'b0, 4'hF, 20'h040), 4'hF);
      push_write(chan_reg(tcdm_dma_pkg::REG_DATA_BASE, 0), 32'h0BAD_F00D, 4'hF);
      wait_idle(4'b0001);
      expect_mem(0, 20'h040, 32'h0BAD_F00D);
      expect_read(chan_reg(tcdm_dma_pkg::REG_DATA_BASE, 0), 32'h0BAD_F00D);
      push_write(chan_reg(tcdm_dma_pkg::REG_CFG_BASE, 1), cfg_word(1'b1, 4'hF, 20'h080), 4'hF);
      push_write(chan_reg(tcdm_dma_pkg::REG_DATA_BASE, 1), 32'h0, 4'hF);
      wait_idle(4'b0010);
      expect_read(chan_reg(tcdm_dma_pkg::REG_DATA_BASE, 1), fill_word(1, 8'h20));
      push_write(chan_reg(tcdm_dma_pkg::REG_CFG_BASE, 2), cfg_word(1'b0, 4'b0011, 20'h010), 4'hF);
      push_write(chan_reg(tcdm_dma_pkg::REG_DATA_BASE, 2), 32'h1111_2222, 4'hF);
      wait_idle(4'b0100);
      w = fill_word(2, 8'h04);
      expect_mem(2, 20'h010, {w[31:16], 16'h2222});
      // read burst of 6 words into buffer 3
      push_write(chan_reg(tcdm_dma_pkg::REG_CFG_BASE, 3), cfg_word(1'b1, 4'hF, 20'h100), 4'hF);
      push_write(chan_reg(tcdm_dma_pkg::REG_LEN_BASE, 3), 32'd6, 4'hF);
      push_write(chan_reg(tcdm_dma_pkg::REG_LAUNCH_BASE, 3), 32'h1, 4'hF);
      wait_idle(4'b1000);
      for (int k = 0; k < 6; k++)
         expect_read(buf_word(3, k), fill_word(3, 8'(8'h40 + k)));
      expect_read(buf_word(3, 63), 32'h5EED_003F);   // beyond the burst
      // write bursts on all four channels at once
      len = 8;
      for (int c = 0; c < 4; c++) begin
         base = 20'h300 + 20'(c * 32);
         for (int k = 0; k < len; k++)
            push_write(buf_word(c, k), {8'hB0, 8'(c), 16'(k)}, 4'hF);
         push_write(chan_reg(tcdm_dma_pkg::REG_CFG_BASE, c), cfg_word(1'b0, 4'hF, base), 4'hF);
         push_write(chan_reg(tcdm_dma_pkg::REG_LEN_BASE, c), 32'(len), 4'hF);
      end
      for (int c = 0; c < 4; c++)
         push_write(chan_reg(tcdm_dma_pkg::REG_LAUNCH_BASE, c), 32'h0, 4'hF);
      wait_idle(4'hF);
      for (int c = 0; c < 4; c++) begin
         base = 20'h300 + 20'(c * 32);
         for (int k = 0; k < len; k++)
            expect_mem(c, base + 20'(4 * k), {8'hB0, 8'(c), 16'(k)});
         expect_mem(c, base + 20'(4 * len), fill_word(c, base[9:2] + 8'(len)));  // untouched
      end
   endtask

   initial begin
      step_t       s;
      logic [31:0] rdata;
      bus_req   = 1'b0;
      bus_req_p = '0;
      reset     = 1'b1;
      build_table();
      limit = steps.size() * 64;
      repeat (5) @(posedge CLK);
      reset <= 1'b0;
      for (int i = 0; i < steps.size(); i++) begin
         s = steps[i];
         case (s.op)
            OP_WR: bus_access(1'b1, s.addr, s.data, s.be, rdata);
            OP_RD: begin
               bus_access(1'b0, s.addr, 32'h0, s.be, rdata);
               compare($sformatf("bus_rdata @%h", s.addr), rdata, s.exp);
            end
            OP_POLL: begin
               bus_access(1'b0, s.addr, 32'h0, s.be, rdata);
               while ((rdata[3:0] & s.data[3:0]) != 4'h0)
                  bus_access(1'b0, s.addr, 32'h0, s.be, rdata);
            end
            default: compare($sformatf("tcdm%0d mem @%h", s.port, s.addr),
                             peek_mem(s.port, s.addr), s.exp);
         endcase
      end
      $display("run complete: %0d errors in %0d checks", errors, checks);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

//--- project.f
logic/tcdm_dma_pkg.sv
logic/chan_buffer.sv
logic/tcdm_channel.sv
logic/tcdm_regs.sv
logic/tcdm_dma_top.sv
verif/tcdm_mem_model.sv
verif/tb_tcdm_dma.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_tcdm_dma
FILELIST  := project.f
BUILD     := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD)
